// ==== design/soc_pkg.sv ====
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] mask_t;
    typedef logic [63:0] cycle_t;

    // RAM size in 32-bit words.
    localparam int RAM_WORDS = 4096;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    typedef logic [RAM_IDX_W-1:0] ram_idx_t;

    // Region bases.
    localparam addr_t RAM_BASE = 32'h0000_0000;
    localparam addr_t LEDS_BASE = 32'h0001_0000;
    localparam addr_t TIMER_BASE = 32'h0003_0000;

    // Timer word offsets.
    localparam logic [3:0] TIMER_CNT_LO = 4'h0;
    localparam logic [3:0] TIMER_CNT_HI = 4'h4;
    localparam logic [3:0] TIMER_CMP_LO = 4'h8;
    localparam logic [3:0] TIMER_CMP_HI = 4'hC;

    // Request is a level, held until the ready pulse.
    typedef struct packed {
        addr_t address;
        logic read;
        logic write;
        mask_t mask;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        logic ready;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        INSTR,
        DATA
    } arb_state_t;

endpackage

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input bus_req_t instr_req,
    input bus_req_t data_req,
    output bus_rsp_t instr_rsp,
    output bus_rsp_t data_rsp,
    output bus_req_t mem_req,
    input bus_rsp_t mem_rsp
);

    arb_state_t owner;
    arb_state_t grant;
    logic instr_pend;
    logic data_pend;

    assign instr_pend = instr_req.read | instr_req.write;
    assign data_pend = data_req.read | data_req.write;

    // Data port wins a tie. Grant takes effect in the same cycle.
    always_comb begin
        grant = owner;
        if (owner == IDLE) begin
            if (data_pend) begin
                grant = DATA;
            end else if (instr_pend) begin
                grant = INSTR;
            end
        end
    end

    always_comb begin
        mem_req = '0;
        case (grant)
            INSTR: begin
                mem_req = instr_req;
                // Fetch port never writes.
                mem_req.write = 1'b0;
            end
            DATA: begin
                mem_req = data_req;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // Only the owner sees the response.
    always_comb begin
        instr_rsp = '0;
        data_rsp = '0;
        if (grant == INSTR) begin
            instr_rsp = mem_rsp;
        end
        if (grant == DATA) begin
            data_rsp = mem_rsp;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            owner <= IDLE;
        end else if (mem_rsp.ready) begin
            owner <= IDLE;
        end else begin
            owner <= grant;
        end
    end

    // A ready only reaches a port that still holds its request.
    a_ready_to_requester: assert property (
        @(posedge pll_clk) disable iff (!rst_n)
        (!instr_rsp.ready || instr_pend) && (!data_rsp.ready || data_pend)
    );

endmodule

// ==== design/mem_router.sv ====
`timescale 1ns/1ps

module mem_router
    import soc_pkg::*;
(
    input bus_req_t mem_req,
    output logic ram_sel,
    output logic regs_sel,
    input bus_rsp_t ram_rsp,
    input bus_rsp_t regs_rsp,
    output bus_rsp_t mem_rsp
);

    logic active;
    logic ram_hit;
    logic leds_hit;
    logic timer_hit;
    logic unmapped;

    assign active = mem_req.read | mem_req.write;

    // 64 KiB window, the RAM aliases inside it.
    assign ram_hit = mem_req.address[31:16] == RAM_BASE[31:16];
    assign leds_hit = mem_req.address[31:2] == LEDS_BASE[31:2];
    assign timer_hit = mem_req.address[31:4] == TIMER_BASE[31:4];

    assign ram_sel = active && ram_hit;
    assign regs_sel = active && (leds_hit || timer_hit);
    assign unmapped = active && !(ram_hit || leds_hit || timer_hit);

    // Targets drive zero when idle, so a plain OR merges them.
    // Unmapped accesses complete at once with zero data.
    assign mem_rsp.rdata = ram_rsp.rdata | regs_rsp.rdata;
    assign mem_rsp.ready = ram_rsp.ready | regs_rsp.ready | unmapped;

    // The OR merge needs a single responder.
    always_comb begin
        a_one_resp: assert final (!(ram_rsp.ready && (regs_rsp.ready || unmapped)));
    end

endmodule

// ==== design/ram.sv ====
`timescale 1ns/1ps

module ram
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input logic sel,
    input bus_req_t mem_req,
    output bus_rsp_t rsp
);

    word_t mem [RAM_WORDS];
    word_t rdata_q;
    logic ready_q;
    ram_idx_t idx;

    assign idx = mem_req.address[RAM_IDX_W+1:2];

    // Write once, in the first selected cycle.
    always_ff @(posedge pll_clk) begin
        if (sel && mem_req.write && !ready_q) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req.mask[i]) begin
                    mem[idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                end
            end
        end
        rdata_q <= mem[idx];
    end

    // Single ready pulse one cycle after select.
    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= sel && !ready_q;
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = ready_q ? rdata_q : '0;

    // Requester holds the access through the wait cycle.
    a_sel_held: assert property (
        @(posedge pll_clk) disable iff (!rst_n)
        (sel && !ready_q) |=> sel
    );

endmodule

// ==== design/sys_regs.sv ====
`timescale 1ns/1ps

module sys_regs
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input logic sel,
    input bus_req_t mem_req,
    output bus_rsp_t rsp,
    output logic [7:0] leds,
    output logic timer_irq
);

    logic [7:0] leds_q;
    cycle_t cnt;
    cycle_t cmp;
    logic timer_hit;
    logic wr;
    logic [3:0] offs;
    word_t rd_val;

    assign timer_hit = mem_req.address[31:16] == TIMER_BASE[31:16];
    assign offs = mem_req.address[3:0];
    assign wr = sel && mem_req.write;

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            leds_q <= '0;
        end else if (wr && !timer_hit && mem_req.mask[0]) begin
            leds_q <= mem_req.wdata[7:0];
        end
    end

    // Free-running, not writable from the bus.
    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Compare written by halves, byte by byte.
    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            cmp <= '1;
        end else if (wr && timer_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req.mask[i]) begin
                    if (offs == TIMER_CMP_LO) begin
                        cmp[8*i +: 8] <= mem_req.wdata[8*i +: 8];
                    end else if (offs == TIMER_CMP_HI) begin
                        cmp[32+8*i +: 8] <= mem_req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        rd_val = '0;
        if (timer_hit) begin
            case (offs)
                TIMER_CNT_LO: rd_val = cnt[31:0];
                TIMER_CNT_HI: rd_val = cnt[63:32];
                TIMER_CMP_LO: rd_val = cmp[31:0];
                TIMER_CMP_HI: rd_val = cmp[63:32];
                default: rd_val = '0;
            endcase
        end else begin
            rd_val = {24'b0, leds_q};
        end
    end

    assign rsp.rdata = sel ? rd_val : '0;
    assign rsp.ready = sel;
    assign leds = leds_q;
    assign timer_irq = cnt >= cmp;

endmodule

// ==== design/soc_top.sv ====
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input bus_req_t instr_req,
    output bus_rsp_t instr_rsp,
    input bus_req_t data_req,
    output bus_rsp_t data_rsp,
    output logic [7:0] leds,
    output logic timer_irq
);

    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    bus_rsp_t ram_rsp;
    bus_rsp_t regs_rsp;
    logic ram_sel;
    logic regs_sel;

    bus_arbiter u_arbiter (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .instr_req(instr_req),
        .data_req(data_req),
        .instr_rsp(instr_rsp),
        .data_rsp(data_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    mem_router u_router (
        .mem_req(mem_req),
        .ram_sel(ram_sel),
        .regs_sel(regs_sel),
        .ram_rsp(ram_rsp),
        .regs_rsp(regs_rsp),
        .mem_rsp(mem_rsp)
    );

    ram u_ram (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .sel(ram_sel),
        .mem_req(mem_req),
        .rsp(ram_rsp)
    );

    sys_regs u_regs (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .sel(regs_sel),
        .mem_req(mem_req),
        .rsp(regs_rsp),
        .leds(leds),
        .timer_irq(timer_irq)
    );

endmodule

// ==== tb/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb
    import soc_pkg::*;
();

    localparam int CLK_NS = 10;
    localparam int N_WORDS = 16;
    localparam int N_FETCH = 8;
    localparam int MAX_WAIT = 20;
    // Bus accesses over all tests, with margin.
    localparam int N_ACCESS = 4 * N_WORDS + 4 * N_FETCH + 60;
    localparam int TIMER_WAIT = 300;
    localparam int LIMIT_NS = (N_ACCESS * 8 + TIMER_WAIT + 100) * CLK_NS;

    logic pll_clk;
    logic rst_n;
    bus_req_t instr_req;
    bus_req_t data_req;
    bus_rsp_t instr_rsp;
    bus_rsp_t data_rsp;
    logic [7:0] leds;
    logic timer_irq;

    logic [31:0] lfsr_state = 32'd56;
    int errors = 0;
    int checks = 0;
    word_t ram_model [int];
    logic [7:0] led_model;

    soc_top dut0 (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .instr_req(instr_req),
        .instr_rsp(instr_rsp),
        .data_req(data_req),
        .data_rsp(data_rsp),
        .leds(leds),
        .timer_irq(timer_irq)
    );

    initial begin
        pll_clk = 1'b0;
        forever #(CLK_NS / 2) pll_clk = ~pll_clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("Watchdog timeout: tests still running after %0d ns", LIMIT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    // Galois LFSR, one step per bit.
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'hA300_0000;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic word_t apply_mask(input word_t old, input word_t wdata, input mask_t mask);
        word_t v;
        v = old;
        for (int i = 0; i < 4; i++)
            if (mask[i])
                v[8*i +: 8] = wdata[8*i +: 8];
        return v;
    endfunction

    function automatic addr_t ram_addr(input int idx);
        return RAM_BASE | addr_t'(idx << 2);
    endfunction

    function automatic addr_t timer_addr(input logic [3:0] offs);
        return {TIMER_BASE[31:4], offs};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cycle(input string name, input cycle_t exp, input cycle_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    // Hold the request until a ready is seen mid-cycle, release after that edge.
    task automatic bus_access(input logic is_instr, input bus_req_t req, output word_t rdata);
        bus_rsp_t rsp;
        int cycles;
        logic done;
        rdata = '0;
        cycles = 0;
        done = 1'b0;
        @(negedge pll_clk);
        if (is_instr)
            instr_req = req;
        else
            data_req = req;
        while (!done && cycles < MAX_WAIT) begin
            #1;
            rsp = is_instr ? instr_rsp : data_rsp;
            cycles++;
            if (rsp.ready) begin
                rdata = rsp.rdata;
                done = 1'b1;
            end
            @(negedge pll_clk);
        end
        if (is_instr)
            instr_req = '0;
        else
            data_req = '0;
        if (!done)
            report_failure($sformatf("no ready on the %s port for address %h",
                is_instr ? "instruction" : "data", req.address));
    endtask

    task automatic instr_read(input addr_t a, output word_t rdata);
        bus_req_t r;
        r = '0;
        r.address = a;
        r.read = 1'b1;
        bus_access(1'b1, r, rdata);
    endtask

    task automatic data_read(input addr_t a, output word_t rdata);
        bus_req_t r;
        r = '0;
        r.address = a;
        r.read = 1'b1;
        bus_access(1'b0, r, rdata);
    endtask

    task automatic data_write(input addr_t a, input mask_t m, input word_t wdata);
        bus_req_t r;
        word_t unused;
        r = '0;
        r.address = a;
        r.write = 1'b1;
        r.mask = m;
        r.wdata = wdata;
        bus_access(1'b0, r, unused);
    endtask

    task automatic verify_ram(input string name, input logic use_instr);
        word_t rd;
        foreach (ram_model[idx]) begin
            if (use_instr)
                instr_read(ram_addr(idx), rd);
            else
                data_read(ram_addr(idx), rd);
            check_word($sformatf("%s %h", name, ram_addr(idx)), ram_model[idx], rd);
        end
    endtask

    task automatic read_timer64(input logic [3:0] lo_offs, output cycle_t val);
        word_t lo;
        word_t hi;
        data_read(timer_addr(lo_offs), lo);
        data_read(timer_addr(lo_offs + 4'h4), hi);
        val = {hi, lo};
    endtask

    // Low half first, so the value never drops below the count on the way.
    task automatic write_cmp(input cycle_t v);
        data_write(timer_addr(TIMER_CMP_LO), 4'hF, v[31:0]);
        data_write(timer_addr(TIMER_CMP_HI), 4'hF, v[63:32]);
    endtask

    task automatic ram_masked_test();
        int idx;
        int used [$];
        word_t w;
        mask_t m;
        for (int i = 0; i < N_WORDS; i++) begin
            idx = int'(rand_bits(12));
            w = rand_bits(32);
            data_write(ram_addr(idx), 4'hF, w);
            ram_model[idx] = w;
            used.push_back(idx);
        end
        foreach (used[i]) begin
            m = mask_t'(4'b0001 << rand_bits(2));
            w = rand_bits(32);
            data_write(ram_addr(used[i]), m, w);
            ram_model[used[i]] = apply_mask(ram_model[used[i]], w, m);
        end
        verify_ram("ram_masked", 1'b0);
    endtask

    task automatic instr_fetch_test();
        int idx;
        word_t w;
        for (int i = 0; i < N_FETCH; i++) begin
            idx = int'(rand_bits(12));
            w = rand_bits(32);
            data_write(ram_addr(idx), 4'hF, w);
            ram_model[idx] = w;
        end
        verify_ram("instr_fetch", 1'b1);
    endtask

    task automatic concurrent_test();
        word_t wa;
        word_t wb;
        word_t ra;
        word_t rb;
        time t_data;
        time t_instr;
        wa = rand_bits(32);
        wb = rand_bits(32);
        data_write(ram_addr(256), 4'hF, wa);
        data_write(ram_addr(257), 4'hF, wb);
        ram_model[256] = wa;
        ram_model[257] = wb;
        fork
            begin
                data_read(ram_addr(256), ra);
                t_data = $time;
            end
            begin
                instr_read(ram_addr(257), rb);
                t_instr = $time;
            end
        join
        check_word("concurrent data", wa, ra);
        check_word("concurrent instr", wb, rb);
        if (t_data >= t_instr)
            report_failure("instruction port was served before the data port");
    endtask

    task automatic leds_test();
        word_t w;
        word_t rd;
        w = rand_bits(32);
        led_model = w[7:0];
        data_write(LEDS_BASE, 4'b0001, w);
        check_bit("leds write", led_model, leds);
        data_read(LEDS_BASE, rd);
        check_word("leds read", {24'b0, led_model}, rd);
        data_write(LEDS_BASE, 4'b1110, ~w);
        check_bit("leds masked write", led_model, leds);
    endtask

    task automatic timer_test();
        cycle_t c1;
        cycle_t c2;
        cycle_t c3;
        cycle_t cmp_rd;
        read_timer64(TIMER_CNT_LO, c1);
        read_timer64(TIMER_CNT_LO, c2);
        if (c2 <= c1)
            report_failure($sformatf("timer count did not advance (%0d then %0d)", c1, c2));
        data_write(timer_addr(TIMER_CNT_LO), 4'hF, 32'h0);
        data_write(timer_addr(TIMER_CNT_HI), 4'hF, 32'h0);
        read_timer64(TIMER_CNT_LO, c3);
        if (c3 <= c2)
            report_failure("a write to the timer count changed the count");
        write_cmp(c3 + 64'd200);
        read_timer64(TIMER_CMP_LO, cmp_rd);
        check_cycle("timer cmp", c3 + 64'd200, cmp_rd);
        check_bit("timer_irq before compare", 8'h00, {7'b0, timer_irq});
        repeat (TIMER_WAIT) @(negedge pll_clk);
        check_bit("timer_irq after compare", 8'h01, {7'b0, timer_irq});
        write_cmp('1);
        check_bit("timer_irq cleared", 8'h00, {7'b0, timer_irq});
    endtask

    task automatic unmapped_test();
        addr_t addrs [4];
        word_t rd;
        word_t w;
        addrs = '{32'h0002_0000, 32'h0001_0004, 32'h0003_0010, 32'h8000_0000};
        w = rand_bits(32);
        data_write(ram_addr(0), 4'hF, w);
        ram_model[0] = w;
        foreach (addrs[i]) begin
            data_read(addrs[i], rd);
            check_word($sformatf("unmapped read %h", addrs[i]), 32'h0, rd);
            data_write(addrs[i], 4'hF, rand_bits(32));
        end
        check_bit("unmapped leds", led_model, leds);
        verify_ram("unmapped ram", 1'b0);
    endtask

    initial begin
        rst_n = 1'b0;
        instr_req = '0;
        data_req = '0;
        repeat (4) @(posedge pll_clk);
        @(negedge pll_clk);
        rst_n = 1'b1;
        check_bit("reset leds", 8'h00, leds);
        check_bit("reset irq", 8'h00, {7'b0, timer_irq});
        check_bit("reset ready", 8'h00, {6'b0, instr_rsp.ready, data_rsp.ready});
        ram_masked_test();
        instr_fetch_test();
        concurrent_test();
        leds_test();
        timer_test();
        unmapped_test();
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/soc_pkg.sv
design/bus_arbiter.sv
design/mem_router.sv
design/ram.sv
design/sys_regs.sv
design/soc_top.sv
tb/soc_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module soc_tb --Mdir "$OBJ" -o soc_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/soc_tb_sim" 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
